// File: src/l2_lmem_pkg.sv
package l2_lmem_pkg;

    // default cache geometry, overridden through the top-level parameters
    localparam int num_ways_def = 4;
    localparam int set_bits_def = 6;
    // upper set bits that pick a bank
    localparam int bank_bits_def = 1;

    // line layout
    localparam int words_per_line = 4;
    localparam int word_bits = 32;
    localparam int tag_bits = 20;

    // way number, also used for the evict-way pointer
    localparam int way_bits = 2;

    // number of coherence state bits per word
    localparam int state_bits = 3;

    typedef logic [tag_bits-1:0] l2_tag_t;

    typedef logic [words_per_line*word_bits-1:0] line_t;

    typedef logic hprot_t;

    // zero means invalid
    typedef logic [state_bits-1:0] state_t;

    // one state per word of the line
    typedef state_t [words_per_line-1:0] state_line_t;

    typedef logic [way_bits-1:0] l2_way_t;

endpackage

// File: src/l2_wr_decode.sv
`timescale 1ns/1ps

module l2_wr_decode #(
    parameter int num_ways = l2_lmem_pkg::num_ways_def,
    parameter int bank_bits = l2_lmem_pkg::bank_bits_def
) (
    input logic clk,
    input logic lmem_wr_rst,
    input logic wr_en_fill,
    input logic wr_en_line,
    input logic wr_en_state,
    input logic wr_en_evict_way,
    input l2_lmem_pkg::l2_way_t way_in,
    input logic [bank_bits-1:0] bank_sel,

    output logic [num_ways-1:0][2**bank_bits-1:0] tag_we,
    output logic [num_ways-1:0][2**bank_bits-1:0] hprot_we,
    output logic [num_ways-1:0][2**bank_bits-1:0] line_we,
    output logic [num_ways-1:0][2**bank_bits-1:0] state_we,
    output logic [2**bank_bits-1:0] evict_we
);

    localparam int banks = 2**bank_bits;

    logic [num_ways-1:0] way_oh;
    logic [banks-1:0] bank_oh;
    logic [num_ways-1:0] way_any;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_oh[w] = (way_in == w);
        end
        for (int b = 0; b < banks; b++) begin
            bank_oh[b] = (bank_sel == b);
        end
    end

    // fill writes every field and the partial enables add to it
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            for (int b = 0; b < banks; b++) begin
                logic hit;
                hit = way_oh[w] & bank_oh[b] & ~lmem_wr_rst;
                tag_we[w][b] = hit & wr_en_fill;
                hprot_we[w][b] = hit & wr_en_fill;
                line_we[w][b] = hit & (wr_en_fill | wr_en_line);
                state_we[w][b] = hit & (wr_en_fill | wr_en_state);
            end
        end
        // the evict pointer belongs to the set, not to a way
        for (int b = 0; b < banks; b++) begin
            evict_we[b] = bank_oh[b] & wr_en_evict_way & ~lmem_wr_rst;
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_any[w] = |{tag_we[w], hprot_we[w], line_we[w], state_we[w]};
        end
    end

    // a field write reaches exactly one existing way of the cache
    assert property (@(posedge clk) disable iff (lmem_wr_rst)
        (wr_en_fill | wr_en_line | wr_en_state) |-> $onehot(way_any))
        else $error("l2_wr_decode: field write does not enable exactly one way");

endmodule

// File: src/l2_bank_mem.sv
`timescale 1ns/1ps

module l2_bank_mem #(
    parameter type payload_t = logic,
    parameter int bank_bits = l2_lmem_pkg::bank_bits_def,
    parameter int addr_bits = l2_lmem_pkg::set_bits_def - l2_lmem_pkg::bank_bits_def,
    parameter bit clear_on_rst = 1'b0
) (
    input logic clk,
    input logic lmem_wr_rst,
    input logic rd_en,
    input logic [2**bank_bits-1:0] we,
    input logic [addr_bits-1:0] addr,
    input payload_t wr_data,

    output payload_t rd_data [2**bank_bits]
);

    localparam int banks = 2**bank_bits;
    localparam int depth = 2**addr_bits;

    for (genvar b = 0; b < banks; b++) begin : g_bank
        payload_t mem [depth];

        if (clear_on_rst) begin : g_clr
            // reset wipes the whole bank, writes wait until it is over
            always_ff @(posedge clk) begin
                if (lmem_wr_rst) begin
                    for (int i = 0; i < depth; i++) begin
                        mem[i] <= '0;
                    end
                end else if (we[b]) begin
                    mem[addr] <= wr_data;
                end
            end
        end else begin : g_plain
            always_ff @(posedge clk) begin
                if (we[b]) begin
                    mem[addr] <= wr_data;
                end
            end
        end

        // read-first, the same edge that writes returns the old entry
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_data[b] <= mem[addr];
            end
        end
    end

endmodule

// File: src/l2_way_array.sv
`timescale 1ns/1ps

module l2_way_array #(
    parameter int bank_bits = l2_lmem_pkg::bank_bits_def,
    parameter int addr_bits = l2_lmem_pkg::set_bits_def - l2_lmem_pkg::bank_bits_def
) (
    input logic clk,
    input logic lmem_wr_rst,
    input logic rd_en,
    input logic [addr_bits-1:0] addr,
    input logic [2**bank_bits-1:0] tag_we,
    input logic [2**bank_bits-1:0] hprot_we,
    input logic [2**bank_bits-1:0] line_we,
    input logic [2**bank_bits-1:0] state_we,
    input l2_lmem_pkg::l2_tag_t wr_tag,
    input l2_lmem_pkg::hprot_t wr_hprot,
    input l2_lmem_pkg::line_t wr_line,
    input l2_lmem_pkg::state_line_t wr_state,

    output l2_lmem_pkg::l2_tag_t rd_tag [2**bank_bits],
    output l2_lmem_pkg::hprot_t rd_hprot [2**bank_bits],
    output l2_lmem_pkg::line_t rd_line [2**bank_bits],
    output l2_lmem_pkg::state_line_t rd_state [2**bank_bits]
);

    import l2_lmem_pkg::*;

    l2_bank_mem #(
        .payload_t(l2_tag_t),
        .bank_bits(bank_bits),
        .addr_bits(addr_bits),
        .clear_on_rst(1'b0)
    ) u_tag_mem (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .rd_en(rd_en),
        .we(tag_we),
        .addr(addr),
        .wr_data(wr_tag),
        .rd_data(rd_tag)
    );

    l2_bank_mem #(
        .payload_t(hprot_t),
        .bank_bits(bank_bits),
        .addr_bits(addr_bits),
        .clear_on_rst(1'b0)
    ) u_hprot_mem (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .rd_en(rd_en),
        .we(hprot_we),
        .addr(addr),
        .wr_data(wr_hprot),
        .rd_data(rd_hprot)
    );

    l2_bank_mem #(
        .payload_t(line_t),
        .bank_bits(bank_bits),
        .addr_bits(addr_bits),
        .clear_on_rst(1'b0)
    ) u_line_mem (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .rd_en(rd_en),
        .we(line_we),
        .addr(addr),
        .wr_data(wr_line),
        .rd_data(rd_line)
    );

    // only the state array is cleared, so every line reads invalid after reset
    l2_bank_mem #(
        .payload_t(state_line_t),
        .bank_bits(bank_bits),
        .addr_bits(addr_bits),
        .clear_on_rst(1'b1)
    ) u_state_mem (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .rd_en(rd_en),
        .we(state_we),
        .addr(addr),
        .wr_data(wr_state),
        .rd_data(rd_state)
    );

endmodule

// File: src/l2_rd_select.sv
`timescale 1ns/1ps

module l2_rd_select #(
    parameter int num_ways = l2_lmem_pkg::num_ways_def,
    parameter int bank_bits = l2_lmem_pkg::bank_bits_def
) (
    input logic clk,
    input logic lmem_wr_rst,
    input logic rd_en,
    input logic [bank_bits-1:0] bank_sel,
    input l2_lmem_pkg::l2_tag_t bank_tag [num_ways][2**bank_bits],
    input l2_lmem_pkg::hprot_t bank_hprot [num_ways][2**bank_bits],
    input l2_lmem_pkg::line_t bank_line [num_ways][2**bank_bits],
    input l2_lmem_pkg::state_line_t bank_state [num_ways][2**bank_bits],
    input l2_lmem_pkg::l2_way_t bank_evict [2**bank_bits],

    output l2_lmem_pkg::line_t lmem_rd_data_line [num_ways],
    output l2_lmem_pkg::l2_tag_t lmem_rd_data_tag [num_ways],
    output l2_lmem_pkg::hprot_t lmem_rd_data_hprot [num_ways],
    output l2_lmem_pkg::state_line_t lmem_rd_data_state [num_ways],
    output l2_lmem_pkg::l2_way_t lmem_rd_data_evict_way,
    output logic lmem_rd_valid
);

    // bank of the read in flight is captured on the same edge as the memories
    logic [bank_bits-1:0] bank_q;

    always_ff @(posedge clk) begin
        if (lmem_wr_rst) begin
            bank_q <= '0;
            lmem_rd_valid <= 1'b0;
        end else begin
            lmem_rd_valid <= rd_en;
            if (rd_en) begin
                bank_q <= bank_sel;
            end
        end
    end

    // the memory outputs and bank_q both hold between reads,
    // so the selected values hold too
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            lmem_rd_data_line[w] = bank_line[w][bank_q];
            lmem_rd_data_tag[w] = bank_tag[w][bank_q];
            lmem_rd_data_hprot[w] = bank_hprot[w][bank_q];
            lmem_rd_data_state[w] = bank_state[w][bank_q];
        end
        lmem_rd_data_evict_way = bank_evict[bank_q];
    end

    // the outputs only hold if the memories keep their read data between reads
    for (genvar b = 0; b < 2**bank_bits; b++) begin : g_hold_chk
        assert property (@(posedge clk) disable iff (lmem_wr_rst)
            !rd_en |=> bank_evict[b] === $past(bank_evict[b]))
            else $error("l2_rd_select: evict read data changed without a read");

        for (genvar w = 0; w < num_ways; w++) begin : g_way
            assert property (@(posedge clk) disable iff (lmem_wr_rst)
                !rd_en |=> bank_state[w][b] === $past(bank_state[w][b]))
                else $error("l2_rd_select: state read data changed without a read");
        end
    end

endmodule

// File: src/l2_localmem.sv
`timescale 1ns/1ps

module l2_localmem #(
    parameter int num_ways = l2_lmem_pkg::num_ways_def,
    parameter int set_bits = l2_lmem_pkg::set_bits_def,
    parameter int bank_bits = l2_lmem_pkg::bank_bits_def
) (
    input logic clk,
    input logic lmem_wr_rst,
    input logic lmem_rd_en,
    input logic lmem_wr_en_fill,
    input logic lmem_wr_en_line,
    input logic lmem_wr_en_state,
    input logic lmem_wr_en_evict_way,
    input logic [set_bits-1:0] lmem_set_in,
    input l2_lmem_pkg::l2_way_t lmem_way_in,
    input l2_lmem_pkg::line_t lmem_wr_data_line,
    input l2_lmem_pkg::l2_tag_t lmem_wr_data_tag,
    input l2_lmem_pkg::hprot_t lmem_wr_data_hprot,
    input l2_lmem_pkg::state_line_t lmem_wr_data_state,
    input l2_lmem_pkg::l2_way_t lmem_wr_data_evict_way,

    output l2_lmem_pkg::line_t lmem_rd_data_line [num_ways],
    output l2_lmem_pkg::l2_tag_t lmem_rd_data_tag [num_ways],
    output l2_lmem_pkg::hprot_t lmem_rd_data_hprot [num_ways],
    output l2_lmem_pkg::state_line_t lmem_rd_data_state [num_ways],
    output l2_lmem_pkg::l2_way_t lmem_rd_data_evict_way,
    output logic lmem_rd_valid
);

    import l2_lmem_pkg::*;

    localparam int banks = 2**bank_bits;
    localparam int addr_bits = set_bits - bank_bits;

    // high set bits pick the bank, low bits address inside it
    logic [bank_bits-1:0] bank_sel;
    logic [addr_bits-1:0] bank_addr;

    assign bank_sel = lmem_set_in[set_bits-1 -: bank_bits];
    assign bank_addr = lmem_set_in[addr_bits-1:0];

    logic [num_ways-1:0][banks-1:0] tag_we;
    logic [num_ways-1:0][banks-1:0] hprot_we;
    logic [num_ways-1:0][banks-1:0] line_we;
    logic [num_ways-1:0][banks-1:0] state_we;
    logic [banks-1:0] evict_we;

    l2_tag_t bank_tag [num_ways][banks];
    hprot_t bank_hprot [num_ways][banks];
    line_t bank_line [num_ways][banks];
    state_line_t bank_state [num_ways][banks];
    l2_way_t bank_evict [banks];

    l2_wr_decode #(
        .num_ways(num_ways),
        .bank_bits(bank_bits)
    ) u_wr_decode (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .wr_en_fill(lmem_wr_en_fill),
        .wr_en_line(lmem_wr_en_line),
        .wr_en_state(lmem_wr_en_state),
        .wr_en_evict_way(lmem_wr_en_evict_way),
        .way_in(lmem_way_in),
        .bank_sel(bank_sel),
        .tag_we(tag_we),
        .hprot_we(hprot_we),
        .line_we(line_we),
        .state_we(state_we),
        .evict_we(evict_we)
    );

    // every way is read on its own port in parallel
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        l2_way_array #(
            .bank_bits(bank_bits),
            .addr_bits(addr_bits)
        ) u_way (
            .clk(clk),
            .lmem_wr_rst(lmem_wr_rst),
            .rd_en(lmem_rd_en),
            .addr(bank_addr),
            .tag_we(tag_we[w]),
            .hprot_we(hprot_we[w]),
            .line_we(line_we[w]),
            .state_we(state_we[w]),
            .wr_tag(lmem_wr_data_tag),
            .wr_hprot(lmem_wr_data_hprot),
            .wr_line(lmem_wr_data_line),
            .wr_state(lmem_wr_data_state),
            .rd_tag(bank_tag[w]),
            .rd_hprot(bank_hprot[w]),
            .rd_line(bank_line[w]),
            .rd_state(bank_state[w])
        );
    end

    // one evict pointer per set
    l2_bank_mem #(
        .payload_t(l2_way_t),
        .bank_bits(bank_bits),
        .addr_bits(addr_bits),
        .clear_on_rst(1'b0)
    ) u_evict_mem (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .rd_en(lmem_rd_en),
        .we(evict_we),
        .addr(bank_addr),
        .wr_data(lmem_wr_data_evict_way),
        .rd_data(bank_evict)
    );

    l2_rd_select #(
        .num_ways(num_ways),
        .bank_bits(bank_bits)
    ) u_rd_select (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .rd_en(lmem_rd_en),
        .bank_sel(bank_sel),
        .bank_tag(bank_tag),
        .bank_hprot(bank_hprot),
        .bank_line(bank_line),
        .bank_state(bank_state),
        .bank_evict(bank_evict),
        .lmem_rd_data_line(lmem_rd_data_line),
        .lmem_rd_data_tag(lmem_rd_data_tag),
        .lmem_rd_data_hprot(lmem_rd_data_hprot),
        .lmem_rd_data_state(lmem_rd_data_state),
        .lmem_rd_data_evict_way(lmem_rd_data_evict_way),
        .lmem_rd_valid(lmem_rd_valid)
    );

endmodule

// File: include/l2_lmem_tb_tasks.svh
`ifndef L2_LMEM_TB_TASKS_SVH
`define L2_LMEM_TB_TASKS_SVH

// reference model, indexed by set and way
l2_tag_t model_tag [num_sets][num_ways];
hprot_t model_hprot [num_sets][num_ways];
line_t model_line [num_sets][num_ways];
state_line_t model_state [num_sets][num_ways];
l2_way_t model_evict [num_sets];

int check_count = 0;
int error_count = 0;

task automatic compare_tag(input string test_name, input int way,
                           input l2_tag_t expected, input l2_tag_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s tag way %0d: expected %h actual %h",
                 test_name, way, expected, actual);
    end
endtask

task automatic compare_hprot(input string test_name, input int way,
                             input hprot_t expected, input hprot_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s hprot way %0d: expected %b actual %b",
                 test_name, way, expected, actual);
    end
endtask

task automatic compare_line(input string test_name, input int way,
                            input line_t expected, input line_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s line way %0d: expected %h actual %h",
                 test_name, way, expected, actual);
    end
endtask

task automatic compare_state(input string test_name, input int way,
                             input state_line_t expected, input state_line_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s state way %0d: expected %h actual %h",
                 test_name, way, expected, actual);
    end
endtask

task automatic compare_way(input string test_name, input int set_idx,
                           input l2_way_t expected, input l2_way_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s evict way set %0d: expected %0d actual %0d",
                 test_name, set_idx, expected, actual);
    end
endtask

// drives one write command and applies the field rules to the model
task automatic drive_write(input logic fill, input logic line_en, input logic state_en,
                           input logic evict_en, input int set_idx, input l2_way_t way,
                           input l2_tag_t tag, input hprot_t hprot, input line_t wr_line,
                           input state_line_t state, input l2_way_t evict);
    lmem_wr_en_fill = fill;
    lmem_wr_en_line = line_en;
    lmem_wr_en_state = state_en;
    lmem_wr_en_evict_way = evict_en;
    lmem_set_in = set_bits'(set_idx);
    lmem_way_in = way;
    lmem_wr_data_tag = tag;
    lmem_wr_data_hprot = hprot;
    lmem_wr_data_line = wr_line;
    lmem_wr_data_state = state;
    lmem_wr_data_evict_way = evict;
    if (fill) begin
        model_tag[set_idx][way] = tag;
        model_hprot[set_idx][way] = hprot;
    end
    if (fill || line_en) begin
        model_line[set_idx][way] = wr_line;
    end
    if (fill || state_en) begin
        model_state[set_idx][way] = state;
    end
    // pointer belongs to the set, way input is irrelevant
    if (evict_en) begin
        model_evict[set_idx] = evict;
    end
endtask

task automatic clear_writes();
    lmem_wr_en_fill = 1'b0;
    lmem_wr_en_line = 1'b0;
    lmem_wr_en_state = 1'b0;
    lmem_wr_en_evict_way = 1'b0;
endtask

// lets the driven write pass one rising edge
task automatic commit_write();
    @(negedge clk);
    clear_writes();
endtask

task automatic wait_valid(input int set_idx);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!lmem_rd_valid && cycles < valid_timeout);
    if (!lmem_rd_valid) begin
        $display("read of set %0d timed out, lmem_rd_valid never rose", set_idx);
        $display("Test failed");
        $finish;
    end
endtask

task automatic read_set(input int set_idx);
    lmem_set_in = set_bits'(set_idx);
    lmem_rd_en = 1'b1;
    wait_valid(set_idx);
    lmem_rd_en = 1'b0;
endtask

// every field of every way, plus the evict pointer
task automatic check_set(input string test_name, input int set_idx);
    for (int w = 0; w < num_ways; w++) begin
        compare_tag(test_name, w, model_tag[set_idx][w], lmem_rd_data_tag[w]);
        compare_hprot(test_name, w, model_hprot[set_idx][w], lmem_rd_data_hprot[w]);
        compare_line(test_name, w, model_line[set_idx][w], lmem_rd_data_line[w]);
        compare_state(test_name, w, model_state[set_idx][w], lmem_rd_data_state[w]);
    end
    compare_way(test_name, set_idx, model_evict[set_idx], lmem_rd_data_evict_way);
endtask

`endif

// File: bench/tb_l2_localmem.sv
`timescale 1ns/1ps

module tb_l2_localmem;

    import l2_lmem_pkg::*;

    localparam int num_ways = num_ways_def;
    localparam int set_bits = set_bits_def;
    localparam int bank_bits = bank_bits_def;
    localparam int num_sets = 2**set_bits;
    localparam int valid_timeout = 8;

    logic clk;
    logic lmem_wr_rst;
    logic lmem_rd_en;
    logic lmem_wr_en_fill;
    logic lmem_wr_en_line;
    logic lmem_wr_en_state;
    logic lmem_wr_en_evict_way;
    logic [set_bits-1:0] lmem_set_in;
    l2_way_t lmem_way_in;
    line_t lmem_wr_data_line;
    l2_tag_t lmem_wr_data_tag;
    hprot_t lmem_wr_data_hprot;
    state_line_t lmem_wr_data_state;
    l2_way_t lmem_wr_data_evict_way;

    line_t lmem_rd_data_line [num_ways];
    l2_tag_t lmem_rd_data_tag [num_ways];
    hprot_t lmem_rd_data_hprot [num_ways];
    state_line_t lmem_rd_data_state [num_ways];
    l2_way_t lmem_rd_data_evict_way;
    logic lmem_rd_valid;

    int errors_at_start;
    int tests_run = 0;
    int tests_with_errors = 0;

    `include "l2_lmem_tb_tasks.svh"

    l2_localmem #(
        .num_ways(num_ways),
        .set_bits(set_bits),
        .bank_bits(bank_bits)
    ) dut (
        .clk(clk),
        .lmem_wr_rst(lmem_wr_rst),
        .lmem_rd_en(lmem_rd_en),
        .lmem_wr_en_fill(lmem_wr_en_fill),
        .lmem_wr_en_line(lmem_wr_en_line),
        .lmem_wr_en_state(lmem_wr_en_state),
        .lmem_wr_en_evict_way(lmem_wr_en_evict_way),
        .lmem_set_in(lmem_set_in),
        .lmem_way_in(lmem_way_in),
        .lmem_wr_data_line(lmem_wr_data_line),
        .lmem_wr_data_tag(lmem_wr_data_tag),
        .lmem_wr_data_hprot(lmem_wr_data_hprot),
        .lmem_wr_data_state(lmem_wr_data_state),
        .lmem_wr_data_evict_way(lmem_wr_data_evict_way),
        .lmem_rd_data_line(lmem_rd_data_line),
        .lmem_rd_data_tag(lmem_rd_data_tag),
        .lmem_rd_data_hprot(lmem_rd_data_hprot),
        .lmem_rd_data_state(lmem_rd_data_state),
        .lmem_rd_data_evict_way(lmem_rd_data_evict_way),
        .lmem_rd_valid(lmem_rd_valid)
    );

    always #20 clk = ~clk;

    function automatic line_t random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic state_line_t random_state();
        state_line_t s;
        for (int i = 0; i < words_per_line; i++) begin
            s[i] = state_t'($urandom);
        end
        return s;
    endfunction

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string test_name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            tests_with_errors++;
            $display("%s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic reset_clears_state();
        start_test();
        for (int s = 0; s < num_sets; s++) begin
            read_set(s);
            for (int w = 0; w < num_ways; w++) begin
                compare_state("reset_clears_state", w, '0, lmem_rd_data_state[w]);
            end
        end
        finish_test("reset_clears_state");
    endtask

    // known contents everywhere with a pattern that mixes the whole set and way
    task automatic preload_all();
        state_line_t st;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int i = 0; i < words_per_line; i++) begin
                    st[i] = state_t'(s + w * 3 + i);
                end
                drive_write(1'b1, 1'b0, 1'b0, w == 0, s, l2_way_t'(w),
                            l2_tag_t'(s * 37 + w * 11 + 20'h1000), hprot_t'(^(s ^ w)),
                            {4{16'(s), 16'(w) ^ 16'ha5a5}}, st,
                            l2_way_t'(s ^ (s >> 2) ^ (s >> 4)));
                commit_write();
            end
        end
    endtask

    task automatic fill_one_way();
        start_test();
        preload_all();
        drive_write(1'b1, 1'b0, 1'b0, 1'b0, 9, 2'd3, l2_tag_t'($urandom), 1'b1,
                    random_line(), random_state(), 2'd0);
        commit_write();
        read_set(9);
        check_set("fill_one_way", 9);
        finish_test("fill_one_way");
    endtask

    // the other fields get random data that must be ignored
    task automatic partial_writes();
        start_test();
        drive_write(1'b0, 1'b1, 1'b0, 1'b0, 20, 2'd1, l2_tag_t'($urandom),
                    hprot_t'($urandom), random_line(), random_state(), 2'd0);
        commit_write();
        read_set(20);
        check_set("partial_writes", 20);
        drive_write(1'b0, 1'b0, 1'b1, 1'b0, 20, 2'd1, l2_tag_t'($urandom),
                    hprot_t'($urandom), random_line(), random_state(), 2'd0);
        commit_write();
        read_set(20);
        check_set("partial_writes", 20);
        finish_test("partial_writes");
    endtask

    task automatic evict_per_bank();
        int set_a;
        int set_b;
        start_test();
        // same bank address, different bank
        set_a = 5;
        set_b = 5 + num_sets / 2;
        drive_write(1'b0, 1'b0, 1'b0, 1'b1, set_a, l2_way_t'($urandom), l2_tag_t'($urandom),
                    1'b0, random_line(), random_state(), 2'd1);
        commit_write();
        drive_write(1'b0, 1'b0, 1'b0, 1'b1, set_b, l2_way_t'($urandom), l2_tag_t'($urandom),
                    1'b0, random_line(), random_state(), 2'd3);
        commit_write();
        read_set(set_a);
        check_set("evict_per_bank", set_a);
        read_set(set_b);
        check_set("evict_per_bank", set_b);
        finish_test("evict_per_bank");
    endtask

    task automatic read_during_write();
        l2_tag_t old_tag;
        hprot_t old_hprot;
        line_t old_line;
        state_line_t old_state;
        start_test();
        old_tag = model_tag[12][2];
        old_hprot = model_hprot[12][2];
        old_line = model_line[12][2];
        old_state = model_state[12][2];
        drive_write(1'b1, 1'b0, 1'b0, 1'b0, 12, 2'd2, l2_tag_t'($urandom), ~old_hprot,
                    random_line(), random_state(), 2'd0);
        lmem_rd_en = 1'b1;
        wait_valid(12);
        clear_writes();
        // same edge as the write, so the old entry comes back
        compare_tag("read_during_write", 2, old_tag, lmem_rd_data_tag[2]);
        compare_hprot("read_during_write", 2, old_hprot, lmem_rd_data_hprot[2]);
        compare_line("read_during_write", 2, old_line, lmem_rd_data_line[2]);
        compare_state("read_during_write", 2, old_state, lmem_rd_data_state[2]);
        wait_valid(12);
        lmem_rd_en = 1'b0;
        check_set("read_during_write", 12);
        finish_test("read_during_write");
    endtask

    task automatic random_sweep();
        logic [3:0] cmd;
        start_test();
        for (int n = 0; n < 300; n++) begin
            cmd = 4'($urandom_range(1, 15));
            drive_write(cmd[3], cmd[2], cmd[1], cmd[0], $urandom_range(0, num_sets - 1),
                        l2_way_t'($urandom), l2_tag_t'($urandom), hprot_t'($urandom),
                        random_line(), random_state(), l2_way_t'($urandom));
            commit_write();
        end
        for (int s = 0; s < num_sets; s++) begin
            read_set(s);
            check_set("random_sweep", s);
        end
        finish_test("random_sweep");
    endtask

    initial begin
        void'($urandom(32'h358a));
        clk = 1'b0;
        lmem_wr_rst = 1'b1;
        lmem_rd_en = 1'b0;
        clear_writes();
        lmem_set_in = '0;
        lmem_way_in = '0;
        lmem_wr_data_line = '0;
        lmem_wr_data_tag = '0;
        lmem_wr_data_hprot = '0;
        lmem_wr_data_state = '0;
        lmem_wr_data_evict_way = '0;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                model_state[s][w] = '0;
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        lmem_wr_rst = 1'b0;
        reset_clears_state();
        fill_one_way();
        partial_writes();
        evict_per_bank();
        read_during_write();
        random_sweep();
        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_with_errors, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
src/l2_lmem_pkg.sv
src/l2_wr_decode.sv
src/l2_bank_mem.sv
src/l2_way_array.sv
src/l2_rd_select.sv
src/l2_localmem.sv
bench/tb_l2_localmem.sv
